// ==== icache_addr_pkg.sv ====
// Address side types of the instruction cache: fetch address fields and stored tag entry
`include "icache_config.svh"

package icache_addr_pkg;

   // Line size in bytes and derived field widths
   localparam int unsigned LINE_BYTES     = `REFILL_DATA_WIDTH / 8;
   localparam int unsigned NB_SETS        = `CACHE_SIZE / (`NB_WAYS * LINE_BYTES);
   localparam int unsigned OFFSET_WIDTH   = $clog2(LINE_BYTES);
   localparam int unsigned INDEX_WIDTH    = $clog2(NB_SETS);
   localparam int unsigned WORD_SEL_WIDTH = $clog2(`REFILL_DATA_WIDTH / `FETCH_DATA_WIDTH);
   localparam int unsigned TAG_WIDTH      = `FETCH_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

   typedef logic [`FETCH_ADDR_WIDTH-1:0] fetch_addr_t;
   typedef logic [TAG_WIDTH-1:0]         tag_t;
   typedef logic [INDEX_WIDTH-1:0]       index_t;
   typedef logic [WORD_SEL_WIDTH-1:0]    word_sel_t;

   // One tag storage row, valid bit on top
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   // Field extraction, address layout is tag | index | offset
   function automatic tag_t addr_tag(fetch_addr_t addr);
      return addr[`FETCH_ADDR_WIDTH-1 -: TAG_WIDTH];
   endfunction

   function automatic index_t addr_index(fetch_addr_t addr);
      return addr[OFFSET_WIDTH +: INDEX_WIDTH];
   endfunction

   // Word position skips the byte-in-word bits
   function automatic word_sel_t addr_word_sel(fetch_addr_t addr);
      return addr[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
   endfunction

   // Line aligned address, offset bits cleared
   function automatic fetch_addr_t line_base(fetch_addr_t addr);
      return {addr[`FETCH_ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
   endfunction

endpackage

// ==== icache_config.svh ====
// Size and width settings of the instruction cache, included by the packages, RTL and testbench
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

////////////////////
// Port widths
////////////////////

// Byte address on the fetch port
`define FETCH_ADDR_WIDTH 32

// One instruction word per fetch
`define FETCH_DATA_WIDTH 32

// One full cache line per refill response
`define REFILL_DATA_WIDTH 128

////////////////////
// Cache geometry
////////////////////

// Associativity
`define NB_WAYS 2

// Total capacity in bytes, all ways together
`define CACHE_SIZE 512

// Outstanding line addresses between controller and refill port
`define REFILL_BUFF_DEPTH 2

`endif

// ==== icache_controller.sv ====
// Instruction cache controller: lookup, miss refill, round-robin victim choice and flush walk
`include "icache_config.svh"

module icache_controller (
   input  logic                         clk,
   input  logic                         rst_n,
   // Processor fetch port
   input  logic                         fetch_req_i,
   input  icache_addr_pkg::fetch_addr_t fetch_addr_i,
   output logic                         fetch_gnt_o,
   output logic                         fetch_rvalid_o,
   output icache_line_pkg::fetch_word_t fetch_rdata_o,
   // Whole-cache flush
   input  logic                         flush_icache_i,
   output logic                         cache_is_flushed_o,
   // Per-way storage ports
   icache_ram_if.ctrl                   tag_port [`NB_WAYS],
   icache_ram_if.ctrl                   data_port [`NB_WAYS],
   // Refill request toward the buffer
   output logic                         refill_req_o,
   input  logic                         refill_gnt_i,
   output icache_addr_pkg::fetch_addr_t refill_addr_o,
   // Refill response
   input  logic                         refill_r_valid_i,
   input  icache_line_pkg::line_t       refill_r_data_i
);
   import icache_addr_pkg::*;
   import icache_line_pkg::*;

   ctrl_state_t state_q;
   fetch_addr_t addr_q;
   index_t      flush_set_q;
   way_sel_t    victim_q;
   logic        flushed_q;
   logic        flush_pend_q;
   logic        flush_req;
   logic        resp_valid_q;
   line_t       resp_line_q;
   logic        rvalid_q;
   fetch_word_t rdata_q;
   tag_entry_t  tag_rdata [`NB_WAYS];
   line_t       data_rdata [`NB_WAYS];
   way_sel_t    hit_way;
   line_t       hit_line;
   index_t      ram_addr;
   tag_entry_t  tag_wdata;

   // Word out of a line, word 0 in the low bits
   function automatic fetch_word_t pick_word(line_t line, word_sel_t sel);
      return line[sel*$bits(fetch_word_t) +: $bits(fetch_word_t)];
   endfunction

   ////////////////////
   // Fetch handshake
   ////////////////////

   // Nothing to do if the cache is already clean
   assign flush_req = (flush_icache_i & ~flushed_q) | flush_pend_q;

   // Grant only from IDLE, flush has priority
   assign fetch_gnt_o = fetch_req_i & (state_q == IDLE) & ~flush_req;

   assign fetch_rvalid_o     = rvalid_q;
   assign fetch_rdata_o      = rdata_q;
   assign cache_is_flushed_o = flushed_q;

   ////////////////////
   // Storage access
   ////////////////////

   // Shared set address for all ways
   always_comb begin
      case (state_q)
         FLUSH:   ram_addr = flush_set_q;
         WRITE:   ram_addr = addr_index(addr_q);
         // Lookup read uses the address under grant
         default: ram_addr = addr_index(fetch_addr_i);
      endcase
   end

   // Flush writes an all-clear entry
   always_comb begin
      if (state_q == FLUSH) begin
         tag_wdata = '0;
      end else begin
         tag_wdata.valid = 1'b1;
         tag_wdata.tag   = addr_tag(addr_q);
      end
   end

   for (genvar w = 0; w < `NB_WAYS; w++) begin : gen_way
      // Tags: read on grant, all ways cleared in a flush, victim written on refill
      assign tag_port[w].rd_en = fetch_gnt_o;
      assign tag_port[w].wr_en = (state_q == FLUSH) | ((state_q == WRITE) & victim_q[w]);
      assign tag_port[w].addr  = ram_addr;
      assign tag_port[w].wdata = tag_wdata;
      // Lines: read alongside the tags, victim written with the refill line
      assign data_port[w].rd_en = fetch_gnt_o;
      assign data_port[w].wr_en = (state_q == WRITE) & victim_q[w];
      assign data_port[w].addr  = ram_addr;
      assign data_port[w].wdata = resp_line_q;

      assign tag_rdata[w]  = tag_port[w].rdata;
      assign data_rdata[w] = data_port[w].rdata;

      // Tag compare against the registered fetch address
      assign hit_way[w] = tag_rdata[w].valid & (tag_rdata[w].tag == addr_tag(addr_q));
   end

   // At most one way hits, so an OR of the masked lines selects it
   always_comb begin
      hit_line = '0;
      for (int w = 0; w < `NB_WAYS; w++) begin
         if (hit_way[w]) begin
            hit_line = hit_line | data_rdata[w];
         end
      end
   end

   ////////////////////
   // Refill side
   ////////////////////

   assign refill_req_o  = (state_q == REFILL_REQ);
   assign refill_addr_o = line_base(addr_q);

   // Delay register for the valid strobe
   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         resp_valid_q <= 1'b0;
      end else begin
         resp_valid_q <= refill_r_valid_i;
      end
   end

   // Keep the line until the next response
   always_ff @(posedge clk) begin
      if (refill_r_valid_i) begin
         resp_line_q <= refill_r_data_i;
      end
   end

   ////////////////////
   // Main FSM
   ////////////////////

   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         // Reset runs a full flush walk
         state_q      <= FLUSH;
         flush_set_q  <= '0;
         victim_q     <= way_sel_t'(1);
         flushed_q    <= 1'b0;
         flush_pend_q <= 1'b0;
         rvalid_q     <= 1'b0;
      end else begin
         rvalid_q <= 1'b0;
         // Remember a flush that arrives while busy
         if (flush_icache_i & ~flushed_q & (state_q != FLUSH)) begin
            flush_pend_q <= 1'b1;
         end
         case (state_q)
            IDLE: begin
               if (flush_req) begin
                  state_q      <= FLUSH;
                  flush_pend_q <= 1'b0;
               end else if (fetch_req_i) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               if (|hit_way) begin
                  rvalid_q <= 1'b1;
                  state_q  <= IDLE;
               end else begin
                  state_q <= REFILL_REQ;
               end
            end
            REFILL_REQ: begin
               // Buffer full holds us here
               if (refill_gnt_i) begin
                  state_q <= REFILL_WAIT;
               end
            end
            REFILL_WAIT: begin
               if (resp_valid_q) begin
                  state_q <= WRITE;
               end
            end
            WRITE: begin
               rvalid_q  <= 1'b1;
               flushed_q <= 1'b0;
               // Round robin over the ways
               victim_q  <= {victim_q[`NB_WAYS-2:0], victim_q[`NB_WAYS-1]};
               state_q   <= IDLE;
            end
            FLUSH: begin
               if (flush_set_q == index_t'(NB_SETS-1)) begin
                  flush_set_q <= '0;
                  flushed_q   <= 1'b1;
                  state_q     <= IDLE;
               end else begin
                  flush_set_q <= flush_set_q + 1'b1;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Fetch address and response word
   always_ff @(posedge clk) begin
      if (fetch_gnt_o) begin
         addr_q <= fetch_addr_i;
      end
      if (state_q == LOOKUP) begin
         rdata_q <= pick_word(hit_line, addr_word_sel(addr_q));
      end else if (state_q == WRITE) begin
         // Miss answer comes straight from the refill line
         rdata_q <= pick_word(resp_line_q, addr_word_sel(addr_q));
      end
   end

endmodule

// ==== icache_line_pkg.sv ====
// Data side types of the instruction cache: stored line, fetch word, way mask and controller state
`include "icache_config.svh"

package icache_line_pkg;

   // Full refill line as held in a data way
   typedef logic [`REFILL_DATA_WIDTH-1:0] line_t;

   // Word returned to the processor
   typedef logic [`FETCH_DATA_WIDTH-1:0] fetch_word_t;

   // One bit per way, used for hit and victim masks
   typedef logic [`NB_WAYS-1:0] way_sel_t;

   ////////////////////
   // Controller FSM
   ////////////////////

   // IDLE        waits for a fetch or a flush
   // LOOKUP      compares tags read in the grant cycle
   // REFILL_REQ  hands the line address to the request buffer
   // REFILL_WAIT waits for the registered refill response
   // WRITE       fills the victim way and answers the fetch
   // FLUSH       clears one set per cycle
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      REFILL_REQ,
      REFILL_WAIT,
      WRITE,
      FLUSH
   } ctrl_state_t;

endpackage

// ==== icache_ram_if.sv ====
// One read/write port of a way's storage, shared by tag and data ways through a type parameter
interface icache_ram_if #(
   parameter type entry_t = logic
);
   import icache_addr_pkg::*;

   // Read returns rdata one cycle after rd_en
   logic   rd_en;
   // Write lands at the edge with wr_en high
   logic   wr_en;
   index_t addr;
   entry_t wdata;
   // Holds its value while rd_en is low
   entry_t rdata;

   // Controller side
   modport ctrl (
      output rd_en,
      output wr_en,
      output addr,
      output wdata,
      input  rdata
   );

   // Storage side
   modport mem (
      input  rd_en,
      input  wr_en,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

// ==== icache_refill_buffer.sv ====
// Small FIFO of line-aligned refill addresses between the cache controller and the refill port
`include "icache_config.svh"

module icache_refill_buffer (
   input  logic                         clk,
   input  logic                         rst_n,
   // Push side, from the controller
   input  logic                         push_req_i,
   input  icache_addr_pkg::fetch_addr_t push_addr_i,
   output logic                         push_gnt_o,
   // Pop side, external refill port
   output logic                         refill_req_o,
   output icache_addr_pkg::fetch_addr_t refill_addr_o,
   input  logic                         refill_gnt_i
);
   import icache_addr_pkg::*;

   localparam int unsigned DEPTH     = `REFILL_BUFF_DEPTH;
   localparam int unsigned PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   fetch_addr_t          entry_q [DEPTH];
   logic [PTR_WIDTH-1:0] wr_ptr_q;
   logic [PTR_WIDTH-1:0] rd_ptr_q;
   logic [PTR_WIDTH:0]   count_q;
   logic                 push;
   logic                 pop;

   ////////////////////
   // Handshakes
   ////////////////////

   // Accept while a slot is free
   assign push_gnt_o = (count_q != (PTR_WIDTH+1)'(DEPTH));
   assign push       = push_req_i & push_gnt_o;

   // Head entry stays put until the port grants it
   assign refill_req_o  = (count_q != '0);
   assign refill_addr_o = entry_q[rd_ptr_q];
   assign pop           = refill_req_o & refill_gnt_i;

   ////////////////////
   // Pointers and count
   ////////////////////

   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
         end
         // Simultaneous push and pop leave the count alone
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Entry storage, offset bits zeroed on the way in
   always_ff @(posedge clk) begin
      if (push) begin
         entry_q[wr_ptr_q] <= line_base(push_addr_i);
      end
   end

endmodule

// ==== icache_way_ram.sv ====
// Storage of one cache way, one row per set, instantiated once for tags and once for lines
module icache_way_ram #(
   parameter type entry_t = logic
) (
   input logic        clk,
   input logic        rst_n,
   icache_ram_if.mem  port_mem
);
   import icache_addr_pkg::*;

   // One entry per set
   entry_t mem_q [NB_SETS];

   // Write port
   // Valid bits are cleared by the flush walk, not here
   always_ff @(posedge clk) begin
      if (port_mem.wr_en) begin
         mem_q[port_mem.addr] <= port_mem.wdata;
      end
   end

   // Synchronous read register
   // Keeps the last read while idle
   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         port_mem.rdata <= '0;
      end else if (port_mem.rd_en) begin
         // Old contents on a same-cycle write
         port_mem.rdata <= mem_q[port_mem.addr];
      end
   end

endmodule

// ==== pri_icache.sv ====
// Top level of the private instruction cache, connects the processor fetch port to a refill port
`include "icache_config.svh"

module pri_icache (
   input  logic                          clk,
   input  logic                          rst_n,
   // Processor fetch port
   input  logic                          fetch_req_i,
   input  logic [`FETCH_ADDR_WIDTH-1:0]  fetch_addr_i,
   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic [`FETCH_DATA_WIDTH-1:0]  fetch_rdata_o,
   // Refill port
   output logic                          refill_req_o,
   input  logic                          refill_gnt_i,
   output logic [`FETCH_ADDR_WIDTH-1:0]  refill_addr_o,
   input  logic                          refill_r_valid_i,
   input  logic [`REFILL_DATA_WIDTH-1:0] refill_r_data_i,
   // Flush control
   input  logic                          flush_icache_i,
   output logic                          cache_is_flushed_o
);
   import icache_addr_pkg::*;
   import icache_line_pkg::*;

   // Controller to request buffer
   logic        refill_req_int;
   logic        refill_gnt_int;
   fetch_addr_t refill_addr_int;

   // One port per way for tags and for lines
   icache_ram_if #(.entry_t(tag_entry_t)) tag_if [`NB_WAYS] ();
   icache_ram_if #(.entry_t(line_t))      data_if [`NB_WAYS] ();

   ////////////////////
   // Controller
   ////////////////////

   icache_controller i_controller (
      .clk                ( clk                ),
      .rst_n              ( rst_n              ),
      .fetch_req_i        ( fetch_req_i        ),
      .fetch_addr_i       ( fetch_addr_i       ),
      .fetch_gnt_o        ( fetch_gnt_o        ),
      .fetch_rvalid_o     ( fetch_rvalid_o     ),
      .fetch_rdata_o      ( fetch_rdata_o      ),
      .flush_icache_i     ( flush_icache_i     ),
      .cache_is_flushed_o ( cache_is_flushed_o ),
      .tag_port           ( tag_if             ),
      .data_port          ( data_if            ),
      .refill_req_o       ( refill_req_int     ),
      .refill_gnt_i       ( refill_gnt_int     ),
      .refill_addr_o      ( refill_addr_int    ),
      .refill_r_valid_i   ( refill_r_valid_i   ),
      .refill_r_data_i    ( refill_r_data_i    )
   );

   ////////////////////
   // Way storage
   ////////////////////

   for (genvar w = 0; w < `NB_WAYS; w++) begin : gen_way
      icache_way_ram #(.entry_t(tag_entry_t)) i_tag_ram (
         .clk      ( clk       ),
         .rst_n    ( rst_n     ),
         .port_mem ( tag_if[w] )
      );

      icache_way_ram #(.entry_t(line_t)) i_data_ram (
         .clk      ( clk        ),
         .rst_n    ( rst_n      ),
         .port_mem ( data_if[w] )
      );
   end

   // Decouples miss detection from the external grant
   icache_refill_buffer i_refill_buffer (
      .clk           ( clk             ),
      .rst_n         ( rst_n           ),
      .push_req_i    ( refill_req_int  ),
      .push_addr_i   ( refill_addr_int ),
      .push_gnt_o    ( refill_gnt_int  ),
      .refill_req_o  ( refill_req_o    ),
      .refill_addr_o ( refill_addr_o   ),
      .refill_gnt_i  ( refill_gnt_i    )
   );

endmodule

// ==== project.f ====
+incdir+.
icache_addr_pkg.sv
icache_line_pkg.sv
icache_ram_if.sv
icache_way_ram.sv
icache_refill_buffer.sv
icache_controller.sv
pri_icache.sv
tb_refill_mem.sv
tb_pri_icache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_pri_icache -f project.f

output=$(./obj_dir/Vtb_pri_icache 2>&1) || true
echo "$output"

if echo "$output" | grep -qxF '>>> PASS'; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// ==== tb_pri_icache.sv ====
// Testbench for the instruction cache, runs directed fetch and flush sequences under assertions
`include "icache_config.svh"

module tb_pri_icache;
   timeunit 1ns;
   timeprecision 1ps;

   // Scrambles the line pattern so that words differ from their addresses
   localparam logic [31:0] PATTERN_KEY = 32'h5A3C_96E1;
   // Sequence needs about 1000 cycles, four times that as the limit
   localparam int unsigned MAX_CYCLES  = 4000;

   logic                          clk = 1'b0;
   logic                          rst_n;
   logic                          fetch_req_i;
   logic [`FETCH_ADDR_WIDTH-1:0]  fetch_addr_i;
   logic                          fetch_gnt_o;
   logic                          fetch_rvalid_o;
   logic [`FETCH_DATA_WIDTH-1:0]  fetch_rdata_o;
   logic                          refill_req_o;
   logic                          refill_gnt_i;
   logic [`FETCH_ADDR_WIDTH-1:0]  refill_addr_o;
   logic                          refill_r_valid_i;
   logic [`REFILL_DATA_WIDTH-1:0] refill_r_data_i;
   logic                          flush_icache_i;
   logic                          cache_is_flushed_o;

   // Testbench state seen by the assertions
   string       test_name = "reset";
   // Test that issued the fetch in flight
   string       fetch_test = "reset";
   logic        gnt_hold = 1'b0;
   logic        flushing = 1'b0;
   int          exp_refills = 0;
   int          refill_count = 0;
   int unsigned cycle_count = 0;
   logic [31:0] gnt_addr_q = '0;
   logic [31:0] prev_refill_addr = '0;
   logic [31:0] exp_word;
   logic [31:0] exp_line_addr;

   always #4 clk = ~clk;

   pri_icache pri_icache_i (.*);

   tb_refill_mem #(
      .PATTERN_KEY ( PATTERN_KEY ),
      .RAND_SEED   ( 80          )
   ) i_refill_mem (
      .clk       ( clk              ),
      .rst_n     ( rst_n            ),
      .hold_i    ( gnt_hold         ),
      .req_i     ( refill_req_o     ),
      .addr_i    ( refill_addr_o    ),
      .gnt_o     ( refill_gnt_i     ),
      .r_valid_o ( refill_r_valid_i ),
      .r_data_o  ( refill_r_data_i  )
   );

   // Line base plus four bytes per word position, then the key
   function automatic logic [31:0] expect_word(logic [31:0] addr);
      logic [31:0] base;
      logic [1:0]  word;
      base = {addr[31:4], 4'h0};
      word = addr[3:2];
      return (base + {28'h0, word, 2'b00}) ^ PATTERN_KEY;
   endfunction

   task automatic stop_on_failure(input string reason);
      $display("%s", reason);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic report_value(input string check, input logic [31:0] exp, input logic [31:0] act);
      stop_on_failure($sformatf("** Error: test %s, %s: expected %h, actual %h",
                                fetch_test, check, exp, act));
   endtask

   ////////////////////
   // Reference tracking
   ////////////////////

   assign exp_word      = expect_word(gnt_addr_q);
   assign exp_line_addr = {gnt_addr_q[31:4], 4'h0};

   // Granted address and refills seen since that grant
   always @(posedge clk) begin
      prev_refill_addr <= refill_addr_o;
      if (fetch_gnt_o) begin
         gnt_addr_q   <= fetch_addr_i;
         fetch_test   <= test_name;
         refill_count <= 0;
      end else if (refill_req_o && refill_gnt_i) begin
         refill_count <= refill_count + 1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == MAX_CYCLES) begin
         stop_on_failure("Timeout: the DUT stopped answering before the sequence ended");
      end
   end

   ////////////////////
   // Assertions
   ////////////////////

   a_reset_idle: assert property (@(posedge clk)
      $rose(rst_n) |-> !fetch_gnt_o && !fetch_rvalid_o && !refill_req_o && !cache_is_flushed_o)
      else stop_on_failure("Outputs were not idle right after reset");

   a_fetch_data: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_o |-> fetch_rdata_o == exp_word)
      else report_value("fetch data", $sampled(exp_word), $sampled(fetch_rdata_o));

   // Zero for a hit, one for a miss
   a_refill_count: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_o |-> refill_count == exp_refills)
      else report_value("refill count", $sampled(exp_refills), $sampled(refill_count));

   // A fetch that should hit never reaches the refill port
   a_no_refill_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o |-> exp_refills != 0)
      else stop_on_failure("Refill requested while the fetch in flight should hit");

   a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_o && exp_refills == 0 |-> $past(fetch_gnt_o, 2))
      else stop_on_failure("Hit response did not come 2 cycles after its grant");

   a_refill_addr: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o |-> refill_addr_o == exp_line_addr)
      else report_value("refill address", $sampled(exp_line_addr), $sampled(refill_addr_o));

   // Request and address hold until granted
   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && !refill_gnt_i |=> refill_req_o)
      else stop_on_failure("Refill request dropped without a grant");

   a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && !refill_gnt_i |=> refill_addr_o == prev_refill_addr)
      else report_value("refill address hold", $sampled(prev_refill_addr),
                        $sampled(refill_addr_o));

   a_flush_gnt: assert property (@(posedge clk) disable iff (!rst_n)
      flushing && !cache_is_flushed_o |-> !fetch_gnt_o)
      else stop_on_failure("Fetch granted during a flush walk");

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic request_fetch(input logic [31:0] addr, input int refills);
      fetch_req_i  <= 1'b1;
      fetch_addr_i <= addr;
      exp_refills  <= refills;
      do @(posedge clk); while (!fetch_gnt_o);
      fetch_req_i <= 1'b0;
   endtask

   task automatic wait_response();
      do @(posedge clk); while (!fetch_rvalid_o);
   endtask

   task automatic fetch_word(input logic [31:0] addr, input int refills);
      request_fetch(addr, refills);
      wait_response();
   endtask

   initial begin
      rst_n          = 1'b0;
      fetch_req_i    = 1'b0;
      fetch_addr_i   = '0;
      flush_icache_i = 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      test_name = "miss_fill";
      fetch_word(32'h0000_1000, 1);
      // All four word positions from the filled line
      test_name = "hit_words";
      fetch_word(32'h0000_1004, 0);
      fetch_word(32'h0000_1008, 0);
      fetch_word(32'h0000_100C, 0);
      fetch_word(32'h0000_1000, 0);

      // Three lines on set 0, the first one is gone
      test_name = "victim";
      fetch_word(32'h0000_2000, 1);
      fetch_word(32'h0000_3000, 1);
      fetch_word(32'h0000_1008, 1);
      fetch_word(32'h0000_3004, 0);

      test_name = "backpressure";
      gnt_hold <= 1'b1;
      request_fetch(32'h0000_4010, 1);
      repeat (10) @(posedge clk);
      gnt_hold <= 1'b0;
      wait_response();
      fetch_word(32'h0000_401C, 0);

      // Flush and a waiting fetch start on the same edge
      test_name = "flush";
      flushing       <= 1'b1;
      flush_icache_i <= 1'b1;
      fetch_req_i    <= 1'b1;
      fetch_addr_i   <= 32'h0000_3008;
      exp_refills    <= 1;
      @(posedge clk);
      flush_icache_i <= 1'b0;
      while (!fetch_gnt_o) @(posedge clk);
      fetch_req_i <= 1'b0;
      flushing    <= 1'b0;
      wait_response();
      fetch_word(32'h0000_100C, 1);
      fetch_word(32'h0000_1000, 0);

      repeat (4) @(posedge clk);
      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== tb_refill_mem.sv ====
// Refill memory model for the cache testbench, grants line requests and answers with pattern lines
`include "icache_config.svh"

module tb_refill_mem #(
   parameter logic [`FETCH_ADDR_WIDTH-1:0] PATTERN_KEY = '0,
   parameter int unsigned                  RAND_SEED   = 1
) (
   input  logic                          clk,
   input  logic                          rst_n,
   // Holds the grant low while set
   input  logic                          hold_i,
   input  logic                          req_i,
   input  logic [`FETCH_ADDR_WIDTH-1:0]  addr_i,
   output logic                          gnt_o,
   output logic                          r_valid_o,
   output logic [`REFILL_DATA_WIDTH-1:0] r_data_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned WORDS = `REFILL_DATA_WIDTH / `FETCH_DATA_WIDTH;

   // Word w of a line is its address plus 4*w, scrambled by the key
   function automatic logic [`REFILL_DATA_WIDTH-1:0] make_line(
      logic [`FETCH_ADDR_WIDTH-1:0] base
   );
      logic [`REFILL_DATA_WIDTH-1:0] line;
      line = '0;
      for (int w = 0; w < WORDS; w++) begin
         line[w*`FETCH_DATA_WIDTH +: `FETCH_DATA_WIDTH] = (base + 32'(4*w)) ^ PATTERN_KEY;
      end
      return line;
   endfunction

   ////////////////////
   // Request and response
   ////////////////////

   // One request at a time, grant and response each after 0 to 3 cycles
   initial begin
      int unsigned                  delay;
      logic [`FETCH_ADDR_WIDTH-1:0] line_addr;
      gnt_o     = 1'b0;
      r_valid_o = 1'b0;
      r_data_o  = '0;
      void'($urandom(RAND_SEED));
      forever begin
         @(posedge clk);
         if (rst_n && req_i && !hold_i) begin
            delay = $urandom_range(3, 0);
            repeat (delay) @(posedge clk);
            // Address is stable while the request waits
            line_addr = addr_i;
            gnt_o <= 1'b1;
            @(posedge clk);
            gnt_o <= 1'b0;
            delay = $urandom_range(3, 0);
            repeat (delay) @(posedge clk);
            // Single cycle response pulse
            r_valid_o <= 1'b1;
            r_data_o  <= make_line(line_addr);
            @(posedge clk);
            r_valid_o <= 1'b0;
         end
      end
   end

endmodule
